/* flist.f */
+incdir+rtl
rtl/cam_pkg.sv
rtl/pixel_assembler.sv
rtl/line_buffer3.sv
rtl/edge_filter3x3.sv
rtl/bin_thumbnail.sv
rtl/cam_edge_top.sv
sim/cam_edge_chk.sv
sim/tb_cam_edge.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_cam_edge
FLIST     = flist.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(filter-out +%,$(shell cat $(FLIST))) rtl/cam_cfg.svh
PASS_MSG  = All tests passed!

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_cam_edge.sv */
`include "cam_cfg.svh"

module tb_cam_edge;
    import cam_pkg::*;

    typedef struct packed {
        int     cyc;                            // cycle where pixel_valid_o is due
        logic   flat;                           // edge must be zero in the flat interior
        luma_t  luma;
        pixel_u orig;
        pixel_u exp;
    } exp_pix_t;

    logic cmos_pclk;
    logic rst_n;
    logic cam_vsync;
    logic cam_href;
    logic [7:0] cam_data;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [`CAM_WB_AW-1:0] wb_adr;
    logic [`CAM_WB_DW-1:0] wb_dat;
    logic wb_ack;
    pixel_u pixel;
    logic pixel_valid;

    int         cyc_cnt = 0;
    exp_pix_t   exp_q [$];                      // expected pixels in order
    int         prev1 [`CAM_LINE_LEN];          // model line memories
    int         prev2 [`CAM_LINE_LEN];
    int         cur [`CAM_LINE_LEN];
    int         w0 [3];                         // model window column as top mid bottom
    int         w1 [3];
    logic [7:0] hi_byte;
    thumb_row_t thumb_exp [`CAM_THUMB_DIM];

    cam_edge_top i_cam_edge_top (.cmos_pclk, .rst_n, .cam_vsync_i(cam_vsync),
        .cam_href_i(cam_href), .cam_data_i(cam_data), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
        .wb_we_i(wb_we), .wb_adr_i(wb_adr), .pixel_o(pixel), .pixel_valid_o(pixel_valid),
        .wb_dat_o(wb_dat), .wb_ack_o(wb_ack));

    initial begin
        cmos_pclk = 1'b0;
        forever #10 cmos_pclk = ~cmos_pclk;
    end

    always @(posedge cmos_pclk) cyc_cnt <= cyc_cnt + 1;

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_pixel(input pixel_u got, input pixel_u exp);
        if (got !== exp) report_failure($sformatf("FAIL pixel_o got %h expected %h", got, exp));
    endtask

    task automatic check_luma(input luma_t got, input luma_t exp);
        if (got !== exp) report_failure($sformatf("FAIL pixel_o rgb sum got %h expected %h",
            got, exp));
    endtask

    task automatic check_row(input int row, input thumb_row_t got, input thumb_row_t exp);
        if (got !== exp) report_failure($sformatf("FAIL wb_dat_o row %0d got %h expected %h",
            row, got, exp));
    endtask

    // ------------------------------
    // reference model for one byte
    // ------------------------------
    task automatic model_byte(input int n, input int x, input logic [7:0] b, input logic flat);
        int c, lum, t1, t2, gx, gy, e;
        exp_pix_t ent;
        logic [6:0] ev;
        if (n % 16 == 0 && x % 16 == 0 && n < 448 && x < 448)
            thumb_exp[n / 16][x / 16] = (b < 8'd128);       // dark sample -> 1
        if (x % 2 == 0) begin
            hi_byte = b;                                    // first byte of the pair
            return;
        end
        c   = x / 2;
        lum = hi_byte[7:3] + {hi_byte[2:0], b[7:5]} + b[4:0];   // r + g + b
        t1  = (n >= 1) ? prev1[c] : 0;                      // zero taps at frame top
        t2  = (n >= 2) ? prev2[c] : 0;
        gx  = (t2 + 2 * t1 + lum) - (w0[0] + 2 * w0[1] + w0[2]);
        gy  = (w0[0] + 2 * w1[0] + t2) - (w0[2] + 2 * w1[2] + lum);
        e   = ((gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy)) >> 2;
        ev  = (e > 127) ? 7'd127 : 7'(e);
        ent.cyc  = cyc_cnt + 4;                             // four register stages
        ent.flat = flat && n >= 2 && c >= 2;
        ent.luma = luma_t'(lum);
        ent.orig = {hi_byte, b};
        if (ev[6:5] == 2'b00) ent.exp = ent.orig;
        else ent.exp = {ev[6:2], ev[6:1], ev[6:2]};         // gray overlay
        exp_q.push_back(ent);
        w0 = w1;
        w1 = '{t2, t1, lum};
        cur[c] = lum;
    endtask

    // output monitor on the falling edge where outputs are settled
    always @(negedge cmos_pclk) begin
        exp_pix_t ent;
        if (pixel_valid === 1'b1) begin
            if (exp_q.size() == 0) report_failure("pixel_valid_o high with no pixel expected");
            ent = exp_q.pop_front();
            if (cyc_cnt != ent.cyc) report_failure($sformatf(
                "pixel_valid_o came at cycle %0d instead of %0d", cyc_cnt, ent.cyc));
            if (ent.exp === ent.orig)
                check_luma(luma_t'(pixel.rgb.r) + luma_t'(pixel.rgb.g) + luma_t'(pixel.rgb.b),
                    ent.luma);
            if (ent.flat) check_pixel(pixel, ent.orig);     // no edge inside flat area
            check_pixel(pixel, ent.exp);
        end
    end

    // ------------------------------
    // stimulus helpers
    // ------------------------------
    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge cmos_pclk);
            if (pixel_valid !== 1'b0 || wb_ack !== 1'b0)
                report_failure("pixel_valid_o or wb_ack_o high while the DUT should be idle");
        end
    endtask

    task automatic drain_pixels();
        int t;
        t = 0;
        while (exp_q.size() != 0) begin
            if (t == 50) report_failure("expected pixels never left the DUT");
            t++;
            @(negedge cmos_pclk);
        end
    endtask

    task automatic drive_frame(input logic flat, input logic [7:0] flat_val);
        int n, x;
        logic [7:0] b;
        cam_vsync = 1'b1;
        repeat (10) @(negedge cmos_pclk);
        for (n = 0; n < 440; n++) begin
            for (x = 0; x < 460; x++) begin
                b = flat ? flat_val : 8'($urandom);
                cam_href = 1'b1;
                cam_data = b;
                model_byte(n, x, b, flat);
                @(negedge cmos_pclk);
            end
            cam_href = 1'b0;
            cam_data = 8'($urandom);                        // junk while href low
            prev2 = prev1;
            prev1 = cur;
            w0 = '{0, 0, 0};                                // zero columns at line start
            w1 = '{0, 0, 0};
            repeat (4 + $urandom % 17) @(negedge cmos_pclk);
        end
        drain_pixels();
        cam_vsync = 1'b0;                                   // image latched in blanking
        expect_quiet(50);
        cam_vsync = 1'b1;
    endtask

    // one wishbone classic cycle and a row check for reads
    task automatic bus_access(input logic we, input int adr);
        int t;
        thumb_row_t exp;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = we;
        wb_adr = adr[`CAM_WB_AW-1:0];
        exp    = (adr < `CAM_THUMB_DIM) ? thumb_exp[adr] : '0;  // past row 27 reads zero
        t = 0;
        @(negedge cmos_pclk);
        while (wb_ack !== 1'b1) begin
            if (t == 20) report_failure("no wb_ack_o for a bus request");
            t++;
            @(negedge cmos_pclk);
        end
        if (!we) check_row(adr, thumb_row_t'(wb_dat), exp);
        if (!we && wb_dat[`CAM_WB_DW-1:`CAM_THUMB_DIM] !== '0)
            report_failure("wb_dat_o has bits set above the row width");
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge cmos_pclk);
        if (wb_ack !== 1'b0) report_failure("wb_ack_o stayed high after the request ended");
    endtask

    initial begin
        int f, r;
        void'($urandom(32'head2_790a));
        rst_n     = 1'b0;
        cam_vsync = 1'b0;
        cam_href  = 1'b0;
        cam_data  = 8'h00;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        expect_quiet(8);                                    // reset held 8 cycles
        rst_n = 1'b1;
        expect_quiet(10);
        for (f = 0; f < 3; f++) begin
            drive_frame(f == 0, 8'($urandom));              // first frame is flat
            for (r = 0; r < `CAM_THUMB_DIM; r++) bus_access(1'b0, r);
            bus_access(1'b1, 3);                            // write is ignored
            bus_access(1'b0, 3);
            bus_access(1'b0, 30);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

/* sim/cam_edge_chk.sv */
module cam_edge_chk (
    input logic cmos_pclk,
    input logic rst_n,
    input logic cyc_i,
    input logic stb_i,
    input logic ack_i,
    input logic pix_valid_i
);

    // ------------------------------
    // wishbone handshake
    // ------------------------------
    ack_single: assert property (@(posedge cmos_pclk) disable iff (!rst_n)
        ack_i |=> !ack_i) else $error("wb_ack_o stayed high for two cycles");

    ack_after_req: assert property (@(posedge cmos_pclk) disable iff (!rst_n)
        ack_i |-> $past(cyc_i && stb_i)) else $error("wb_ack_o without a request");

    // ------------------------------
    // pixel output
    // ------------------------------
    pix_spaced: assert property (@(posedge cmos_pclk) disable iff (!rst_n)
        pix_valid_i |=> !pix_valid_i) else $error("pixel_valid_o on two cycles in a row");

    // outputs idle while reset is held
    reset_quiet: assert property (@(posedge cmos_pclk)
        !rst_n |-> !pix_valid_i && !ack_i) else $error("output active during reset");

endmodule

bind cam_edge_top cam_edge_chk u_chk (
    .cmos_pclk(cmos_pclk), .rst_n(rst_n), .cyc_i(wb_cyc_i), .stb_i(wb_stb_i),
    .ack_i(wb_ack_o), .pix_valid_i(pixel_valid_o)
);

/* rtl/cam_edge_top.sv */
`include "cam_cfg.svh"

module cam_edge_top (
    input  logic                  cmos_pclk,
    input  logic                  rst_n,
    input  logic                  cam_vsync_i,
    input  logic                  cam_href_i,
    input  logic [7:0]            cam_data_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [`CAM_WB_AW-1:0] wb_adr_i,
    output cam_pkg::pixel_u       pixel_o,
    output logic                  pixel_valid_o,
    output logic [`CAM_WB_DW-1:0] wb_dat_o,
    output logic                  wb_ack_o
);
    import cam_pkg::*;

    logic   asm_valid;
    pixel_u asm_pix;
    luma_t  asm_luma;
    logic   asm_eol;
    logic   tap_valid;
    luma_t  tap0;
    luma_t  tap1;
    luma_t  tap2;
    logic   tap_eol;
    logic   edge_valid;
    edge_t  edge_val;
    pixel_u pix_dly [3];                        // line buffer 1 + filter 2 cycles
    pixel_u gray_pix;

    pixel_assembler u_asm (.cmos_pclk, .rst_n, .cam_href_i, .cam_data_i,
        .pix_valid_o(asm_valid), .pix_o(asm_pix), .luma_o(asm_luma), .line_end_o(asm_eol));

    line_buffer3 u_lbuf (.cmos_pclk, .rst_n, .cam_vsync_i, .pix_valid_i(asm_valid),
        .luma_i(asm_luma), .line_end_i(asm_eol), .tap_valid_o(tap_valid),
        .tap0_o(tap0), .tap1_o(tap1), .tap2_o(tap2), .tap_eol_o(tap_eol));

    edge_filter3x3 u_edge (.cmos_pclk, .rst_n, .tap_valid_i(tap_valid), .tap_eol_i(tap_eol),
        .tap0_i(tap0), .tap1_i(tap1), .tap2_i(tap2),
        .edge_valid_o(edge_valid), .edge_o(edge_val));

    bin_thumbnail u_thumb (.cmos_pclk, .rst_n, .cam_vsync_i, .cam_href_i, .cam_data_i,
        .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_o, .wb_ack_o);

    // free running delay, pixels are at least 2 cycles apart
    always_ff @(posedge cmos_pclk) begin
        pix_dly[0] <= asm_pix;
        pix_dly[1] <= pix_dly[0];
        pix_dly[2] <= pix_dly[1];
    end

    // edge strength as gray
    always_comb begin
        gray_pix.rgb.r = edge_val[`CAM_LUMA_W-1 -: 5];
        gray_pix.rgb.g = edge_val[`CAM_LUMA_W-1 -: 6];
        gray_pix.rgb.b = edge_val[`CAM_LUMA_W-1 -: 5];
    end

    assign pixel_o       = (edge_val[`CAM_LUMA_W-1 -: 2] == 2'b00) ? pix_dly[2] : gray_pix;
    assign pixel_valid_o = edge_valid;          // low byte + 4 cycles

endmodule

/* rtl/bin_thumbnail.sv */
`include "cam_cfg.svh"

module bin_thumbnail (
    input  logic                  cmos_pclk,
    input  logic                  rst_n,
    input  logic                  cam_vsync_i,
    input  logic                  cam_href_i,
    input  logic [7:0]            cam_data_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [`CAM_WB_AW-1:0] wb_adr_i,
    output logic [`CAM_WB_DW-1:0] wb_dat_o,
    output logic                  wb_ack_o
);
    import cam_pkg::*;

    localparam int THUMB_BITS = `CAM_THUMB_DIM * `CAM_THUMB_DIM;   // 784 samples
    localparam int SPAN       = `CAM_THUMB_DIM * `CAM_THUMB_STEP;  // 448
    localparam int CNT_W      = $clog2(SPAN) + 1;
    localparam int STEP_LOG   = $clog2(`CAM_THUMB_STEP);

    logic       href_d;
    logic       [CNT_W-1:0] x_q;                // byte in line
    logic       [CNT_W-1:0] y_q;                // line in frame
    logic       smp_en;
    logic       smp_bit;
    logic       wb_req;
    logic       [THUMB_BITS-1:0] bin_shr;       // newest sample enters at the top
    thumb_row_t [`CAM_THUMB_DIM-1:0] bin_img;   // latched image, row r at [r]

    assign smp_en = cam_href_i
                 && x_q[STEP_LOG-1:0] == '0 && y_q[STEP_LOG-1:0] == '0    // 16x16 grid
                 && x_q < CNT_W'(SPAN) && y_q < CNT_W'(SPAN);
    assign smp_bit = (cam_data_i < 8'(`CAM_THUMB_THRESH));                // dark -> 1
    assign wb_req  = wb_cyc_i & wb_stb_i & ~wb_ack_o;

    // ------------------------------
    // counters and bus handshake
    // ------------------------------
    always_ff @(posedge cmos_pclk or negedge rst_n) begin
        if (!rst_n) begin
            href_d   <= 1'b0;
            x_q      <= '0;
            y_q      <= '0;
            wb_ack_o <= 1'b0;
        end else begin
            href_d   <= cam_href_i;
            wb_ack_o <= wb_req;                       // one cycle per request
            if (!cam_href_i) x_q <= '0;
            else if (x_q != '1) x_q <= x_q + 1'b1;    // stops, no wrap onto the grid
            if (!cam_vsync_i) y_q <= '0;
            else if (href_d && !cam_href_i && y_q != '1) y_q <= y_q + 1'b1;
        end
    end

    // ------------------------------
    // sample, latch, read
    // ------------------------------
    always_ff @(posedge cmos_pclk) begin
        if (smp_en) bin_shr <= {smp_bit, bin_shr[THUMB_BITS-1:1]};
        if (!cam_vsync_i) bin_img <= bin_shr;         // blanking copy
        if (wb_req) begin
            if (!wb_we_i && wb_adr_i < `CAM_WB_AW'(`CAM_THUMB_DIM))
                wb_dat_o <= `CAM_WB_DW'(bin_img[wb_adr_i]);
            else
                wb_dat_o <= '0;                       // writes and rows past 27
        end
    end

endmodule

/* rtl/edge_filter3x3.sv */
`include "cam_cfg.svh"

module edge_filter3x3 (
    input  logic           cmos_pclk,
    input  logic           rst_n,
    input  logic           tap_valid_i,
    input  logic           tap_eol_i,
    input  cam_pkg::luma_t tap0_i,
    input  cam_pkg::luma_t tap1_i,
    input  cam_pkg::luma_t tap2_i,
    output logic           edge_valid_o,
    output cam_pkg::edge_t edge_o
);
    import cam_pkg::*;

    localparam int SUM_W    = `CAM_LUMA_W + 2;          // a + 2b + c
    localparam int EDGE_MAX = (1 << `CAM_LUMA_W) - 1;

    // c0 oldest, c1 middle; c2 is the live tap column
    luma_t c0_t;
    luma_t c0_m;
    luma_t c0_b;
    luma_t c1_t;
    luma_t c1_m;
    luma_t c1_b;
    logic  s1_valid;
    logic  [SUM_W-1:0] gx_abs;
    logic  [SUM_W-1:0] gy_abs;
    logic  [SUM_W:0]   mag_sum;
    logic  [SUM_W:0]   mag_shr;

    function automatic logic [SUM_W-1:0] wsum(input luma_t a, input luma_t b, input luma_t c);
        return SUM_W'(a) + (SUM_W'(b) << 1) + SUM_W'(c);
    endfunction

    function automatic logic [SUM_W-1:0] absdiff(input logic [SUM_W-1:0] x,
                                                 input logic [SUM_W-1:0] y);
        return (x > y) ? x - y : y - x;
    endfunction

    // ------------------------------
    // window and stage one
    // ------------------------------
    always_ff @(posedge cmos_pclk or negedge rst_n) begin
        if (!rst_n) begin
            {c0_t, c0_m, c0_b, c1_t, c1_m, c1_b} <= '0;
            s1_valid     <= 1'b0;
            edge_valid_o <= 1'b0;
        end else begin
            s1_valid     <= tap_valid_i;
            edge_valid_o <= s1_valid;
            if (tap_eol_i) begin
                {c0_t, c0_m, c0_b, c1_t, c1_m, c1_b} <= '0;   // zero columns at line start
            end else if (tap_valid_i) begin
                {c0_t, c0_m, c0_b} <= {c1_t, c1_m, c1_b};
                {c1_t, c1_m, c1_b} <= {tap2_i, tap1_i, tap0_i};
            end
        end
    end

    always_ff @(posedge cmos_pclk) begin
        if (tap_valid_i) begin
            gx_abs <= absdiff(wsum(tap2_i, tap1_i, tap0_i), wsum(c0_t, c0_m, c0_b));  // right - left
            gy_abs <= absdiff(wsum(c0_t, c1_t, tap2_i), wsum(c0_b, c1_b, tap0_i));    // top - bottom
        end
        if (s1_valid) edge_o <= (mag_shr > EDGE_MAX) ? edge_t'(EDGE_MAX) : edge_t'(mag_shr);
    end

    // stage two, sum, /4 and clip
    assign mag_sum = {1'b0, gx_abs} + {1'b0, gy_abs};
    assign mag_shr = mag_sum >> 2;

endmodule

/* rtl/line_buffer3.sv */
`include "cam_cfg.svh"

module line_buffer3 (
    input  logic           cmos_pclk,
    input  logic           rst_n,
    input  logic           cam_vsync_i,
    input  logic           pix_valid_i,
    input  cam_pkg::luma_t luma_i,
    input  logic           line_end_i,
    output logic           tap_valid_o,
    output cam_pkg::luma_t tap0_o,
    output cam_pkg::luma_t tap1_o,
    output cam_pkg::luma_t tap2_o,
    output logic           tap_eol_o
);
    import cam_pkg::*;

    localparam int COL_W = $clog2(`CAM_LINE_LEN + 1);

    luma_t mem_a [`CAM_LINE_LEN];
    luma_t mem_b [`CAM_LINE_LEN];
    logic  [COL_W-1:0] col_q;                   // pixel column in the line
    logic  [1:0] lines_q;                       // completed lines, sticks at 2
    logic  sel_q;                               // 0: a = previous, b = older
    logic  col_ok;

    assign col_ok = (col_q < COL_W'(`CAM_LINE_LEN));   // past the end -> zero taps

    // ------------------------------
    // control
    // ------------------------------
    always_ff @(posedge cmos_pclk or negedge rst_n) begin
        if (!rst_n) begin
            tap_valid_o <= 1'b0;
            tap_eol_o   <= 1'b0;
            col_q       <= '0;
            lines_q     <= '0;
            sel_q       <= 1'b0;
        end else begin
            tap_valid_o <= pix_valid_i;
            tap_eol_o   <= line_end_i;
            if (line_end_i || !cam_vsync_i) col_q <= '0;
            else if (pix_valid_i && col_ok) col_q <= col_q + 1'b1;
            if (!cam_vsync_i) lines_q <= '0;          // new frame
            else if (line_end_i && lines_q != 2'd2) lines_q <= lines_q + 1'b1;
            if (line_end_i) sel_q <= ~sel_q;          // current line becomes previous
        end
    end

    // ------------------------------
    // memories, read before write
    // ------------------------------
    always_ff @(posedge cmos_pclk) begin
        if (pix_valid_i) begin
            tap0_o <= luma_i;
            tap1_o <= (col_ok && lines_q != 2'd0) ? (sel_q ? mem_b[col_q] : mem_a[col_q]) : '0;
            tap2_o <= (col_ok && lines_q == 2'd2) ? (sel_q ? mem_a[col_q] : mem_b[col_q]) : '0;
            if (col_ok) begin
                if (sel_q) mem_a[col_q] <= luma_i;   // overwrite the older line
                else mem_b[col_q] <= luma_i;
            end
        end
    end

endmodule

/* rtl/pixel_assembler.sv */
module pixel_assembler (
    input  logic            cmos_pclk,
    input  logic            rst_n,
    input  logic            cam_href_i,
    input  logic [7:0]      cam_data_i,
    output logic            pix_valid_o,
    output cam_pkg::pixel_u pix_o,
    output cam_pkg::luma_t  luma_o,
    output logic            line_end_o
);
    import cam_pkg::*;

    logic   phase_q;                            // 1 = next byte is the low byte
    logic   href_d;                             // for the falling edge
    logic   [7:0] hi_q;                         // held high byte
    pixel_u pix_nxt;
    luma_t  luma_nxt;

    // pair fills through the byte view
    always_comb begin
        pix_nxt.bytes.hi = hi_q;
        pix_nxt.bytes.lo = cam_data_i;
    end

    // and is read back as rgb565
    assign luma_nxt = luma_t'(pix_nxt.rgb.r) + luma_t'(pix_nxt.rgb.g) + luma_t'(pix_nxt.rgb.b);

    always_ff @(posedge cmos_pclk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q     <= 1'b0;
            href_d      <= 1'b0;
            pix_valid_o <= 1'b0;
            line_end_o  <= 1'b0;
        end else begin
            href_d      <= cam_href_i;
            pix_valid_o <= cam_href_i & phase_q;     // low byte sampled now
            line_end_o  <= href_d & ~cam_href_i;     // one pulse per line
            phase_q     <= cam_href_i & ~phase_q;    // restarts while href low
        end
    end

    // payload, no reset
    always_ff @(posedge cmos_pclk) begin
        if (cam_href_i && !phase_q) hi_q <= cam_data_i;
        if (cam_href_i && phase_q) begin
            pix_o  <= pix_nxt;
            luma_o <= luma_nxt;
        end
    end

endmodule

/* rtl/cam_pkg.sv */
`include "cam_cfg.svh"

package cam_pkg;

    // byte view, in sensor order
    typedef struct packed {
        logic [7:0] hi;                        // first byte of the pair
        logic [7:0] lo;                        // second byte
    } pix_bytes_t;

    // rgb565 view of the same word
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } pix_rgb_t;

    typedef union packed {
        pix_bytes_t bytes;                     // filled by the assembler
        pix_rgb_t   rgb;                       // read for luma and overlay
    } pixel_u;

    typedef logic [`CAM_LUMA_W-1:0]    luma_t;      // r + g + b, max 125
    typedef logic [`CAM_LUMA_W-1:0]    edge_t;      // saturated sobel magnitude
    typedef logic [`CAM_THUMB_DIM-1:0] thumb_row_t; // one thumbnail row

endpackage

/* rtl/cam_cfg.svh */
`ifndef CAM_CFG_SVH
`define CAM_CFG_SVH

// ------------------------------
// pixel path
// ------------------------------
`define CAM_LINE_LEN      480     // max pixels per line, sizes the line memories
`define CAM_LUMA_W        7       // r+g+b of rgb565 fits in 7 bits

// ------------------------------
// binarized thumbnail
// ------------------------------
`define CAM_THUMB_DIM     28      // rows and columns
`define CAM_THUMB_STEP    16      // keep every 16th byte and line
`define CAM_THUMB_THRESH  128     // byte below this -> bit set

// wishbone read port
`define CAM_WB_AW         5       // enough for 28 rows
`define CAM_WB_DW         32      // one row per word, zero extended

`endif
